//--- hdl/decode_pkg.sv
/*
 * shared types of the decode stage
 *   fetch packet, class bits, operand selects, micro-op, decoder flags
 *   alu operation codes, exception codes, canonical nop
 */
`default_nettype none

package decode_pkg;

    ////////////////////////////////////////////////////////////
    // fetch side

    // one fetched word as delivered by the fetch unit
    typedef struct packed {
        logic        valid;
        logic        unknown;
        logic [31:0] badv;
        logic [6:0]  exc;
        logic [31:0] pc_next;
        logic [31:0] pc;
        logic [31:0] inst;
    } fetch_pkt_t;

    ////////////////////////////////////////////////////////////
    // micro-op fields

    // one-hot class, all zero for nop or illegal
    typedef struct packed {
        logic alu;
        logic mul;
        logic div;
        logic mem;
        logic br;
        logic csr;
        logic cache;
        logic tlb;
        logic idle;
        logic eret;
        logic bar;
    } itype_t;

    typedef enum logic [1:0] {
        SRC1_RF    = 2'd0,
        SRC1_PC    = 2'd1,
        SRC1_ZERO  = 2'd2,
        SRC1_CNTID = 2'd3
    } src1_sel_t;

    typedef enum logic [1:0] {
        SRC2_RF   = 2'd0,
        SRC2_IMM  = 2'd1,
        SRC2_CNTL = 2'd2,
        SRC2_CNTH = 2'd3
    } src2_sel_t;

    // alu codes follow inst[18:15] of the 3R format
    localparam logic [3:0] ALU_ADD  = 4'b0000;
    localparam logic [3:0] ALU_SUB  = 4'b0010;
    localparam logic [3:0] ALU_SLT  = 4'b0100;
    localparam logic [3:0] ALU_SLTU = 4'b0101;
    localparam logic [3:0] ALU_NOR  = 4'b1000;
    localparam logic [3:0] ALU_AND  = 4'b1001;
    localparam logic [3:0] ALU_OR   = 4'b1010;
    localparam logic [3:0] ALU_XOR  = 4'b1011;
    localparam logic [3:0] ALU_SRA  = 4'b1100;
    localparam logic [3:0] ALU_SLL  = 4'b1110;
    localparam logic [3:0] ALU_SRL  = 4'b1111;

    typedef struct packed {
        logic        valid;
        itype_t      itype;
        src1_sel_t   src1;
        src2_sel_t   src2;
        logic [3:0]  cond;
        logic        sign;
        logic        mem_atomic;
        logic        privileged;
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        logic [31:0] imm;
        logic [31:0] pc;
        logic [31:0] pc_next;
        logic [6:0]  exc;
        logic [31:0] badv;
        logic [31:0] inst;
    } uop_t;

    typedef struct packed {
        logic illegal;
        logic syscall;
        logic brk;
    } dec_flags_t;

    ////////////////////////////////////////////////////////////
    // exception codes and constants

    localparam logic [6:0] EXC_NONE = 7'h00;
    localparam logic [6:0] EXC_SYS  = 7'h0b;
    localparam logic [6:0] EXC_BRK  = 7'h0c;
    localparam logic [6:0] EXC_INE  = 7'h0d;

    // addi.w r0, r0, 0
    localparam logic [31:0] INST_NOP = 32'h0280_0000;

endpackage

`default_nettype wire

//--- hdl/fetch_buffer.sv
/*
 * fetch buffer
 *   prefix count over the valid words of a bundle,
 *   compaction into the low lanes, one register stage
 */
`timescale 1ns/1ns
`default_nettype none

module fetch_buffer import decode_pkg::*; #(
    parameter int LANES = 2
) (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     flush,
    input  wire logic                     fetch_stb,
    input  wire fetch_pkt_t [LANES-1:0]   fetch_bundle,
    output fetch_pkt_t [LANES-1:0]        lane_pkt,
    output logic                          lane_stb
);

    localparam int CW = (LANES > 1) ? $clog2(LANES) : 1;

    logic [CW-1:0]          pos [LANES];
    fetch_pkt_t [LANES-1:0] packed_pkt;
    fetch_pkt_t [LANES-1:0] lane_q;
    logic [LANES-1:0]       vld_q;

    // target lane of each word = number of valid words below it
    always_comb begin
        pos[0] = '0;
        for (int i = 1; i < LANES; i++) begin
            pos[i] = pos[i-1] + CW'(fetch_bundle[i-1].valid);
        end
    end

    always_comb begin
        packed_pkt = '0;
        for (int i = 0; i < LANES; i++) begin
            if (fetch_bundle[i].valid) begin
                packed_pkt[pos[i]] = fetch_bundle[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_stb) begin
            lane_q <= packed_pkt;
        end
    end

    // valid bits live for one cycle only
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q <= '0;
        end else if (flush || !fetch_stb) begin
            vld_q <= '0;
        end else begin
            for (int j = 0; j < LANES; j++) begin
                vld_q[j] <= packed_pkt[j].valid;
            end
        end
    end

    always_comb begin
        lane_pkt = lane_q;
        for (int j = 0; j < LANES; j++) begin
            lane_pkt[j].valid = vld_q[j];
        end
    end

    // compacted, so lane 0 valid is enough
    assign lane_stb = vld_q[0];

endmodule

`default_nettype wire

//--- hdl/inst_decoder.sv
/*
 * single lane instruction decoder, purely combinational
 *   class, operand selects, operation / branch condition,
 *   register numbers, immediate, illegal detection
 */
`timescale 1ns/1ns
`default_nettype none

module inst_decoder import decode_pkg::*; (
    input  wire fetch_pkt_t pkt,
    output uop_t            uop,
    output dec_flags_t      flags
);

    logic [31:0] inst;
    itype_t      ty;
    logic        is_b_or_bl, is_jirl, is_preload, is_pcadd, is_lui;
    logic        is_alu_imm, is_invtlb, is_ecall, is_alu_sfti, is_sra;
    logic        is_time, is_alu, mem_write, is_store;
    logic [3:0]  alu_op;
    logic        alu_op_bad, br_bad, illegal;
    src1_sel_t   src1;
    src2_sel_t   src2;
    logic        is_i12, is_u12, is_i14, is_i16, is_i26, is_i20;

    assign inst = pkt.inst;

    ////////////////////////////////////////////////////////////
    // classification, bit 31 is checked separately
    always_comb begin
        ty       = '0;
        ty.br    = inst[30];
        ty.bar   = inst[30:16] == 15'b011100001110010;
        ty.mem   = inst[30:28] == 3'b010;
        ty.csr   = inst[30:24] == 7'b0000100;
        ty.cache = inst[30:22] == 9'b000011000;
        ty.idle  = inst[30:15] == 16'b0000110010010001;
        ty.eret  = inst[30:10] == 21'b000011001001000001110;
        ty.tlb   = is_invtlb ||
                   (inst[30:13] == 18'b000011001001000001 && inst[12:10] != 3'b110);
        ty.mul   = inst[30:17] == 14'b00000000001110;
        ty.div   = inst[30:17] == 14'b00000000010000;
        ty.alu   = is_alu || is_time || is_sra || is_alu_sfti || is_alu_imm ||
                   is_pcadd || is_lui;
    end

    assign is_b_or_bl  = inst[30:27] == 4'b1010;
    assign is_jirl     = inst[30:26] == 5'b10011;
    assign is_preload  = inst[30:22] == 9'b010101011;
    assign is_pcadd    = inst[30:25] == 6'b001110;
    assign is_lui      = inst[30:25] == 6'b001010;
    assign is_alu_imm  = inst[30:25] == 6'b000001;
    assign is_invtlb   = inst[30:15] == 16'b0000110010010011;
    assign is_ecall    = inst[30:17] == 14'b00000000010101 && !inst[15];
    assign is_alu_sfti = inst[30:20] == 11'b00000000100 && inst[17:15] == 3'b001;
    assign is_sra      = inst[30:15] == 16'b0000000000110000;
    assign is_time     = inst[30:11] == 20'b00000000000000001100;
    assign is_alu      = inst[30:19] == 12'b000000000010;
    assign mem_write   = ty.mem && inst[24];
    // sc.w writes its status to rd, plain stores do not
    assign is_store    = mem_write && inst[27];

    ////////////////////////////////////////////////////////////
    // operand selects and alu operation
    always_comb begin
        if (is_lui) src1 = SRC1_ZERO;
        else if (is_pcadd) src1 = SRC1_PC;
        else if (is_time && !inst[10] && inst[4:0] == 5'd0) src1 = SRC1_CNTID;
        else src1 = SRC1_RF;

        if (is_alu_imm || is_alu_sfti || is_lui || is_pcadd) src2 = SRC2_IMM;
        else if (is_time && !inst[10] && inst[4:0] != 5'd0) src2 = SRC2_CNTL;
        else if (is_time) src2 = SRC2_CNTH;
        else src2 = SRC2_RF;
    end

    always_comb begin
        alu_op     = ALU_ADD;
        alu_op_bad = 1'b0;
        if (is_alu) begin
            alu_op = inst[18:15];
        end else if (is_alu_imm) begin
            case (inst[24:22])
                3'b000:  alu_op = ALU_SLT;
                3'b001:  alu_op = ALU_SLTU;
                3'b010:  alu_op = ALU_ADD;
                3'b101:  alu_op = ALU_AND;
                3'b110:  alu_op = ALU_OR;
                3'b111:  alu_op = ALU_XOR;
                default: alu_op_bad = 1'b1;
            endcase
        end else if (is_alu_sfti) begin
            case (inst[19:18])
                2'b00:   alu_op = ALU_SLL;
                2'b01:   alu_op = ALU_SRL;
                2'b10:   alu_op = ALU_SRA;
                default: alu_op_bad = 1'b1;
            endcase
        end else if (is_sra) begin
            alu_op = ALU_SRA;
        end
    end

    // jirl, b, bl, beq .. bgeu occupy 4'b0011 to 4'b1011
    assign br_bad  = ty.br && (inst[29:26] < 4'b0011 || inst[29:26] > 4'b1011);
    assign illegal = alu_op_bad || br_bad || inst[31] ||
                     (ty == '0 && !is_ecall) || (is_invtlb && inst[4:0] > 5'd6);

    ////////////////////////////////////////////////////////////
    // immediate formats, exactly one is active
    assign is_i12 = ty.cache || (is_alu_imm && !inst[24]) || (ty.mem && inst[27]) ||
                    is_alu_sfti;
    assign is_u12 = is_alu_imm && inst[24];
    assign is_i14 = (ty.mem && !inst[27]) || ty.csr;
    assign is_i16 = ty.br && !is_b_or_bl;
    assign is_i26 = is_b_or_bl;
    assign is_i20 = is_pcadd || is_lui;

    always_comb begin
        uop            = '0;
        uop.valid      = pkt.valid;
        uop.itype      = (inst == INST_NOP || illegal) ? itype_t'('0) : ty;
        uop.src1       = src1;
        uop.src2       = src2;
        uop.cond       = ({4{ty.alu}} & alu_op) |
                         {3'b000, ty.div & inst[15]} |
                         {3'b000, ty.mul & (inst[15] | inst[16])} |
                         ({4{ty.mem}} & {1'b0, inst[24], inst[27] ? inst[23:22] : 2'b10}) |
                         ({4{ty.br}} & inst[29:26]);
        uop.sign       = ((ty.mul || ty.div) && !inst[16]) || (ty.mem && !inst[25]);
        uop.mem_atomic = ty.mem && !inst[27];
        uop.privileged = ty.cache || ty.tlb || ty.csr || ty.eret || ty.idle;

        // bl links through r1
        if (ty.cache || ty.tlb || ty.idle || is_preload || is_store ||
            (ty.br && !is_jirl && inst[29:26] != 4'b0101)) uop.rd = 5'd0;
        else if (inst[30:26] == 5'b10101) uop.rd = 5'd1;
        else uop.rd = inst[4:0] | ({5{is_time}} & inst[9:5]);

        if ((ty.tlb && !is_invtlb) || ty.idle || is_pcadd || is_lui || is_b_or_bl ||
            is_time) uop.rj = 5'd0;
        else uop.rj = inst[9:5];

        // store data and compare operand moved from the rd field
        if (is_alu || is_sra || ty.mul || ty.div || is_invtlb) uop.rk = inst[14:10];
        else if (mem_write || (ty.br && !is_b_or_bl && !is_jirl) || ty.csr) uop.rk = inst[4:0];
        else uop.rk = 5'd0;

        uop.imm = ({32{is_i12}} & {{20{inst[21]}}, inst[21:10]}) |
                  ({32{is_u12}} & {20'd0, inst[21:10]}) |
                  ({32{is_i14}} & {{18{inst[23]}}, inst[23:10]}) |
                  ({32{is_i16}} & {{16{inst[25]}}, inst[25:10]}) |
                  ({32{is_i26}} & {{6{inst[9]}}, inst[9:0], inst[25:10]}) |
                  ({32{is_i20}} & {inst[24:5], 12'd0});

        uop.pc      = pkt.pc;
        uop.pc_next = pkt.pc_next;
        uop.exc     = pkt.exc;
        uop.badv    = pkt.badv;
        uop.inst    = inst;
    end

    assign flags.illegal = illegal;
    assign flags.syscall = is_ecall && inst[16];
    assign flags.brk     = is_ecall && !inst[16];

endmodule

`default_nettype wire

//--- hdl/uop_dispatch.sv
/*
 * dispatch register
 *   per lane exception priority, kill of younger lanes,
 *   registered bundle with uop and exception strobes
 */
`timescale 1ns/1ns
`default_nettype none

module uop_dispatch import decode_pkg::*; #(
    parameter int LANES = 2
) (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     flush,
    input  wire logic                     lane_stb,
    input  wire uop_t [LANES-1:0]         dec_uop,
    input  wire dec_flags_t [LANES-1:0]   dec_flags,
    output logic                          uop_stb,
    output logic                          exc_stb,
    output uop_t [LANES-1:0]              uop_bundle
);

    uop_t [LANES-1:0] nxt;
    logic [LANES-1:0] nxt_vld;
    logic             kill;
    uop_t [LANES-1:0] uop_q;
    logic [LANES-1:0] vld_q;
    logic             take;

    ////////////////////////////////////////////////////////////
    // exception merge, lowest excepting lane ends the bundle
    always_comb begin
        nxt  = dec_uop;
        kill = 1'b0;
        for (int i = 0; i < LANES; i++) begin
            // fetch exception has priority over decode ones
            if (dec_uop[i].exc == EXC_NONE) begin
                if (dec_flags[i].illegal) nxt[i].exc = EXC_INE;
                else if (dec_flags[i].syscall) nxt[i].exc = EXC_SYS;
                else if (dec_flags[i].brk) nxt[i].exc = EXC_BRK;
            end
            nxt_vld[i] = dec_uop[i].valid && !kill;
            if (nxt_vld[i] && nxt[i].exc != EXC_NONE) begin
                kill = 1'b1;
            end
        end
    end

    assign take = lane_stb && !flush;

    always_ff @(posedge clk) begin
        if (lane_stb) begin
            uop_q <= nxt;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            uop_stb <= 1'b0;
            exc_stb <= 1'b0;
            vld_q   <= '0;
        end else begin
            uop_stb <= take;
            exc_stb <= take && kill;
            vld_q   <= take ? nxt_vld : '0;
        end
    end

    always_comb begin
        uop_bundle = uop_q;
        for (int j = 0; j < LANES; j++) begin
            uop_bundle[j].valid = vld_q[j];
        end
    end

endmodule

`default_nettype wire

//--- hdl/decode_stage.sv
/*
 * decode stage top level
 *   fetch buffer, one decoder per lane, dispatch register
 */
`timescale 1ns/1ns
`default_nettype none

module decode_stage import decode_pkg::*; #(
    parameter int LANES = 2
) (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     flush,
    input  wire logic                     fetch_stb,
    input  wire fetch_pkt_t [LANES-1:0]   fetch_bundle,
    output logic                          uop_stb,
    output logic                          exc_stb,
    output uop_t [LANES-1:0]              uop_bundle
);

    fetch_pkt_t [LANES-1:0] lane_pkt;
    logic                   lane_stb;
    uop_t [LANES-1:0]       dec_uop;
    dec_flags_t [LANES-1:0] dec_flags;

    fetch_buffer #(.LANES(LANES)) u_fetch_buffer (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .fetch_stb    (fetch_stb),
        .fetch_bundle (fetch_bundle),
        .lane_pkt     (lane_pkt),
        .lane_stb     (lane_stb)
    );

    // zero latency decode, one per lane
    for (genvar i = 0; i < LANES; i++) begin : g_lane
        inst_decoder u_inst_decoder (
            .pkt   (lane_pkt[i]),
            .uop   (dec_uop[i]),
            .flags (dec_flags[i])
        );
    end

    uop_dispatch #(.LANES(LANES)) u_uop_dispatch (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (flush),
        .lane_stb   (lane_stb),
        .dec_uop    (dec_uop),
        .dec_flags  (dec_flags),
        .uop_stb    (uop_stb),
        .exc_stb    (exc_stb),
        .uop_bundle (uop_bundle)
    );

endmodule

`default_nettype wire

//--- bench/decode_model.svh
/*
 * reference model for the decode stage testbench
 *   instruction template ids, immediate formats,
 *   expected micro-op of one fetched word
 */
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

typedef enum logic [4:0] {
    K_ADD, K_SUB, K_SLTI, K_ANDI, K_SLLI,
    K_PCADDU12I, K_LU12I, K_LDW, K_STW, K_BEQ,
    K_JIRL, K_B, K_BL, K_MUL, K_DIV,
    K_CSRRD, K_SYSCALL, K_BREAK, K_NOP, K_RSVD
} kind_t;

localparam int NUM_KINDS = 20;

function automatic logic [31:0] imm_i12(logic [31:0] w);
    return {{20{w[21]}}, w[21:10]};
endfunction

function automatic logic [31:0] imm_i16(logic [31:0] w);
    return {{16{w[25]}}, w[25:10]};
endfunction

// offs[25:16] sits in the low bits of the word
function automatic logic [31:0] imm_i26(logic [31:0] w);
    return {{6{w[9]}}, w[9:0], w[25:10]};
endfunction

function automatic uop_t predict_uop(kind_t k, fetch_pkt_t p);
    uop_t        u;
    logic [31:0] w;
    w         = p.inst;
    u         = '0;
    u.valid   = p.valid;
    u.rd      = w[4:0];
    u.rj      = w[9:5];
    u.pc      = p.pc;
    u.pc_next = p.pc_next;
    u.exc     = p.exc;
    u.badv    = p.badv;
    u.inst    = w;
    case (k)
        K_ADD, K_SUB: begin
            u.itype.alu = 1'b1;
            u.cond      = (k == K_ADD) ? ALU_ADD : ALU_SUB;
            u.rk        = w[14:10];
        end
        K_SLTI, K_SLLI: begin
            u.itype.alu = 1'b1;
            u.cond      = (k == K_SLTI) ? ALU_SLT : ALU_SLL;
            u.src2      = SRC2_IMM;
            u.imm       = imm_i12(w);
        end
        K_ANDI: begin
            u.itype.alu = 1'b1;
            u.cond      = ALU_AND;
            u.src2      = SRC2_IMM;
            u.imm       = {20'd0, w[21:10]};
        end
        K_PCADDU12I, K_LU12I: begin
            u.itype.alu = 1'b1;
            u.src1      = (k == K_PCADDU12I) ? SRC1_PC : SRC1_ZERO;
            u.src2      = SRC2_IMM;
            u.rj        = 5'd0;
            u.imm       = {w[24:5], 12'd0};
        end
        // word access, signed, store flagged in cond bit 2
        K_LDW, K_STW: begin
            u.itype.mem = 1'b1;
            u.sign      = 1'b1;
            u.imm       = imm_i12(w);
            u.cond      = (k == K_STW) ? 4'b0110 : 4'b0010;
            if (k == K_STW) begin
                u.rd = 5'd0;
                u.rk = w[4:0];
            end
        end
        K_BEQ, K_JIRL: begin
            u.itype.br = 1'b1;
            u.imm      = imm_i16(w);
            u.cond     = (k == K_BEQ) ? 4'b0110 : 4'b0011;
            if (k == K_BEQ) begin
                u.rd = 5'd0;
                u.rk = w[4:0];
            end
        end
        K_B, K_BL: begin
            u.itype.br = 1'b1;
            u.cond     = (k == K_B) ? 4'b0100 : 4'b0101;
            u.rd       = (k == K_BL) ? 5'd1 : 5'd0;
            u.rj       = 5'd0;
            u.imm      = imm_i26(w);
        end
        K_MUL, K_DIV: begin
            u.itype.mul = (k == K_MUL);
            u.itype.div = (k == K_DIV);
            u.sign      = 1'b1;
            u.rk        = w[14:10];
        end
        K_CSRRD: begin
            u.itype.csr  = 1'b1;
            u.privileged = 1'b1;
            u.rk         = w[4:0];
            u.imm        = {{18{w[23]}}, w[23:10]};
        end
        K_SYSCALL, K_BREAK: begin
            if (p.exc == EXC_NONE) u.exc = (k == K_SYSCALL) ? EXC_SYS : EXC_BRK;
        end
        K_NOP: u.src2 = SRC2_IMM;
        // reserved encoding, class bits stay zero
        default: begin
            if (p.exc == EXC_NONE) u.exc = EXC_INE;
        end
    endcase
    return u;
endfunction

`endif

//--- bench/decode_stage_tb.sv
/*
 * testbench for the decode stage
 *   clock and reset, random bundles from an instruction table,
 *   scoreboard queue, per-lane field checks, watchdog
 */
`timescale 1ns/1ns
`default_nettype none

module decode_stage_tb import decode_pkg::*; ();

    localparam int LANES       = 2;
    localparam int CLK_PERIOD  = 40;
    localparam int NUM_BUNDLES = 600;
    localparam int TIMEOUT_NS  = (NUM_BUNDLES + 50) * CLK_PERIOD;

    `include "decode_model.svh"

    // expected dispatch output for one cycle
    typedef struct packed {
        logic             stb;
        logic             exc;
        uop_t [LANES-1:0] lane;
    } expect_t;

    logic                   clk;
    logic                   rst_n;
    logic                   flush;
    logic                   fetch_stb;
    fetch_pkt_t [LANES-1:0] fetch_bundle;
    logic                   uop_stb;
    logic                   exc_stb;
    uop_t [LANES-1:0]       uop_bundle;

    int      seed;
    bit      checking;
    expect_t exp_q [$];

    decode_stage #(.LANES(LANES)) DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .fetch_stb    (fetch_stb),
        .fetch_bundle (fetch_bundle),
        .uop_stb      (uop_stb),
        .exc_stb      (exc_stb),
        .uop_bundle   (uop_bundle)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // error handling

    task automatic stop_with_failure();
        $display("TEST FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic report_mismatch(string name, logic [31:0] exp, logic [31:0] got);
        $display("FAIL at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, got);
        stop_with_failure();
    endtask

    task automatic compare_field(string name, logic [31:0] exp, logic [31:0] got);
        assert (got === exp) else report_mismatch(name, exp, got);
    endtask

    task automatic check_lane(int i, uop_t exp, uop_t got);
        string n;
        n = $sformatf("uop_bundle[%0d].", i);
        compare_field({n, "valid"}, exp.valid, got.valid);
        // fields of a dead lane are don't care
        if (exp.valid) begin
            compare_field({n, "itype"}, exp.itype, got.itype);
            compare_field({n, "src1"}, exp.src1, got.src1);
            compare_field({n, "src2"}, exp.src2, got.src2);
            compare_field({n, "cond"}, exp.cond, got.cond);
            compare_field({n, "sign"}, exp.sign, got.sign);
            compare_field({n, "mem_atomic"}, exp.mem_atomic, got.mem_atomic);
            compare_field({n, "privileged"}, exp.privileged, got.privileged);
            compare_field({n, "rd"}, exp.rd, got.rd);
            compare_field({n, "rj"}, exp.rj, got.rj);
            compare_field({n, "rk"}, exp.rk, got.rk);
            compare_field({n, "imm"}, exp.imm, got.imm);
            compare_field({n, "pc"}, exp.pc, got.pc);
            compare_field({n, "pc_next"}, exp.pc_next, got.pc_next);
            compare_field({n, "exc"}, exp.exc, got.exc);
            compare_field({n, "badv"}, exp.badv, got.badv);
            compare_field({n, "inst"}, exp.inst, got.inst);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus

    // opcode plus random register and immediate fields
    function automatic logic [31:0] make_word(kind_t k);
        logic [31:0] r;
        r = $random(seed);
        case (k)
            K_ADD:       return 32'h0010_0000 | (r & 32'h0000_7fff);
            K_SUB:       return 32'h0011_0000 | (r & 32'h0000_7fff);
            K_SLTI:      return 32'h0200_0000 | (r & 32'h003f_ffff);
            K_ANDI:      return 32'h0340_0000 | (r & 32'h003f_ffff);
            K_SLLI:      return 32'h0040_8000 | (r & 32'h0000_7fff);
            K_PCADDU12I: return 32'h1c00_0000 | (r & 32'h01ff_ffff);
            K_LU12I:     return 32'h1400_0000 | (r & 32'h01ff_ffff);
            K_LDW:       return 32'h2880_0000 | (r & 32'h003f_ffff);
            K_STW:       return 32'h2980_0000 | (r & 32'h003f_ffff);
            K_BEQ:       return 32'h5800_0000 | (r & 32'h03ff_ffff);
            K_JIRL:      return 32'h4c00_0000 | (r & 32'h03ff_ffff);
            K_B:         return 32'h5000_0000 | (r & 32'h03ff_ffff);
            K_BL:        return 32'h5400_0000 | (r & 32'h03ff_ffff);
            K_MUL:       return 32'h001c_0000 | (r & 32'h0000_7fff);
            K_DIV:       return 32'h0020_0000 | (r & 32'h0000_7fff);
            K_CSRRD:     return 32'h0400_0000 | (r & 32'h00ff_fc1f);
            K_SYSCALL:   return 32'h002b_0000 | (r & 32'h0000_7fff);
            K_BREAK:     return 32'h002a_0000 | (r & 32'h0000_7fff);
            K_NOP:       return INST_NOP;
            // empty opcode space, bit 31 random
            default:     return r & 32'h8000_03ff;
        endcase
    endfunction

    task automatic drive_bundle();
        expect_t    e;
        fetch_pkt_t p;
        kind_t      k;
        int         n_out;
        logic       killed;
        e         = '0;
        n_out     = 0;
        killed    = 1'b0;
        fetch_stb = ($random(seed) & 7) != 0;
        flush     = ($random(seed) & 31) == 0;
        for (int i = 0; i < LANES; i++) begin
            k         = kind_t'(($random(seed) & 32'h7fff_ffff) % NUM_KINDS);
            p.valid   = ($random(seed) & 3) != 0;
            p.unknown = $random(seed);
            p.inst    = make_word(k);
            p.pc      = $random(seed) & ~32'h3;
            p.pc_next = p.pc + 32'd4;
            p.badv    = $random(seed);
            p.exc     = EXC_NONE;
            if (($random(seed) & 7) == 0) p.exc = 7'h01 + ($random(seed) & 7'h3e);
            fetch_bundle[i] = p;
            // valid words fill the low lanes in order
            if (p.valid) begin
                e.lane[n_out] = predict_uop(k, p);
                n_out++;
            end
        end
        // lanes behind the first exception die
        for (int i = 0; i < n_out; i++) begin
            if (killed) e.lane[i].valid = 1'b0;
            else if (e.lane[i].exc != EXC_NONE) killed = 1'b1;
        end
        e.stb = fetch_stb && n_out > 0;
        e.exc = e.stb && killed;
        if (!e.stb || flush) e = '0;
        // flush also drops the bundle still in the fetch buffer
        if (flush) exp_q[exp_q.size() - 1] = '0;
        exp_q.push_back(e);
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence, scoreboard, watchdog

    initial begin
        seed         = 32'hc1c3;
        checking     = 1'b0;
        rst_n        = 1'b0;
        flush        = 1'b0;
        fetch_stb    = 1'b0;
        fetch_bundle = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        // first bundle shows up at the third check
        repeat (3) exp_q.push_back('0);
        checking = 1'b1;
        for (int n = 0; n < NUM_BUNDLES; n++) begin
            @(negedge clk);
            drive_bundle();
        end
        repeat (4) begin
            @(negedge clk);
            fetch_stb = 1'b0;
            flush     = 1'b0;
            exp_q.push_back('0);
        end
        @(negedge clk);
        $display("TEST OK");
        $finish;
    end

    always @(posedge clk) begin : scoreboard
        expect_t e;
        if (checking) begin
            assert (exp_q.size() > 0) else begin
                $display("ERROR: scoreboard queue ran empty at %0t ns", $time);
                stop_with_failure();
            end
            e = exp_q.pop_front();
            compare_field("uop_stb", e.stb, uop_stb);
            compare_field("exc_stb", e.exc, exc_stb);
            for (int i = 0; i < LANES; i++) begin
                check_lane(i, e.lane[i], uop_bundle[i]);
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("ERROR: watchdog expired after %0d ns, the run did not finish", TIMEOUT_NS);
        stop_with_failure();
    end

endmodule

`default_nettype wire

//--- decode_sys.f
+incdir+bench
hdl/decode_pkg.sv
hdl/fetch_buffer.sv
hdl/inst_decoder.sv
hdl/uop_dispatch.sv
hdl/decode_stage.sv
bench/decode_stage_tb.sv
